// File: Bender.yml
package:
  name: rv32i_core

sources:
  - verilog/Types.sv
  - verilog/StageIf.sv
  - verilog/Decoder_RV32I.sv
  - verilog/RegisterFile.sv
  - verilog/FetchStage.sv
  - verilog/DecodeStage.sv
  - verilog/ExecuteStage.sv
  - verilog/Core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/CoreTb.sv

// File: tests/IsaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

localparam logic [31:0] ECALL_WORD  = 32'h0000_0073;
localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

function automatic logic [31:0] regOp(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OpCode_Op};
endfunction

function automatic logic [31:0] immOp(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input OpCode op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] branchTo(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OpCode_Branch};
endfunction

function automatic logic [31:0] upperImm(input logic [19:0] imm, input logic [4:0] rd,
                                         input OpCode op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] jumpTo(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, OpCode_JAL};
endfunction

function automatic void emit(input logic [31:0] word);
    allWords.push_back(word);
endfunction

// LUI plus ADDI, upper part rounded for the sign of the low 12 bits
function automatic void setConst(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(upperImm(upper[31:12], rd, OpCode_LUI));
    emit(immOp(value[11:0], rd, 3'b000, rd, OpCode_OpIMM));
endfunction

function automatic logic [31:0] aluResult(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3:    return (a < b) ? 32'd1 : 32'd0;
        3'd4:    return a ^ b;
        3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

// Runs the loaded program one instruction at a time, records each retire
task automatic runModel();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nextPc;
    logic        writes;
    logic        done;
    int          steps;

    regs = '{default: '0};
    pc = RESET_ADDR;
    done = 1'b0;
    steps = 0;
    expPc.delete();
    expRd.delete();
    expData.delete();
    while (!done) begin
        w = progMem[pc[9:2]];
        a = regs[w[19:15]];
        b = regs[w[24:20]];
        nextPc = pc + 32'd4;
        writes = 1'b1;
        res = '0;
        case (w[6:0])
            OpCode_LUI:   res = {w[31:12], 12'b0};
            OpCode_AUIPC: res = pc + {w[31:12], 12'b0};
            OpCode_JAL: begin
                res = pc + 32'd4;
                nextPc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            OpCode_JALR: begin
                res = pc + 32'd4;
                nextPc = (a + {{20{w[31]}}, w[31:20]}) & 32'hffff_fffe;
            end
            OpCode_Branch: begin
                writes = 1'b0;
                if (branchTaken(w[14:12], a, b))
                    nextPc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            OpCode_OpIMM:
                res = aluResult(w[14:12], w[14:12] == 3'd5 && w[30], a, {{20{w[31]}}, w[31:20]});
            OpCode_Op:
                res = aluResult(w[14:12], w[30], a, b);
            default: begin                          // ECALL or EBREAK
                writes = 1'b0;
                done = 1'b1;
            end
        endcase
        if (!writes || w[11:7] == 5'd0) begin
            expRd.push_back(5'd0);
            expData.push_back(32'd0);
        end
        else begin
            regs[w[11:7]] = res;
            expRd.push_back(w[11:7]);
            expData.push_back(res);
        end
        expPc.push_back(pc);
        pc = nextPc;
        steps++;
        if (steps > 1000 && !done) begin
            noteProblem("reference model ran 1000 steps without reaching a halt");
            done = 1'b1;
        end
    end
    modelCount = expPc.size();
endtask

function automatic void buildPrograms();
    logic [2:0] aluF3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
    logic [6:0] aluF7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20,
                               7'h00, 7'h00};
    logic [2:0] brF3 [6]   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    logic [4:0] brA [3]    = '{5'd1, 5'd2, 5'd1};
    logic [4:0] brB [3]    = '{5'd2, 5'd1, 5'd1};

    progStart[0] = allWords.size();
    testName[0]  = "register-register ALU";
    setConst(5'd1, $random(seed));
    setConst(5'd2, $random(seed));
    setConst(5'd3, $random(seed) | 32'h8000_0000);    // Negative operand
    setConst(5'd4, $random(seed) & 32'h7fff_ffff);
    for (int i = 0; i < 10; i++) begin
        emit(regOp(aluF7[i], 5'd2, 5'd1, aluF3[i], 5'(5 + i)));
        emit(regOp(aluF7[i], 5'd4, 5'd3, aluF3[i], 5'(15 + i)));
    end
    emit(regOp(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));      // Write to x0
    emit(ECALL_WORD);
    progLen[0] = allWords.size() - progStart[0];

    progStart[1] = allWords.size();
    testName[1]  = "immediate forms";
    setConst(5'd1, $random(seed));
    setConst(5'd2, $random(seed) | 32'h8000_0000);
    emit(immOp(12'hffb, 5'd1, 3'd0, 5'd3, OpCode_OpIMM));
    emit(immOp(12'h800, 5'd2, 3'd0, 5'd4, OpCode_OpIMM));
    emit(immOp(12'hfff, 5'd2, 3'd2, 5'd5, OpCode_OpIMM));
    emit(immOp(12'hfff, 5'd1, 3'd3, 5'd6, OpCode_OpIMM));
    emit(immOp(12'd100, 5'd1, 3'd2, 5'd7, OpCode_OpIMM));
    emit(immOp(12'd5, 5'd2, 3'd3, 5'd8, OpCode_OpIMM));
    emit(immOp(12'ha5a, 5'd1, 3'd4, 5'd9, OpCode_OpIMM));
    emit(immOp(12'h0f0, 5'd2, 3'd6, 5'd10, OpCode_OpIMM));
    emit(immOp(12'hf0f, 5'd1, 3'd7, 5'd11, OpCode_OpIMM));
    emit(immOp(12'd7, 5'd1, 3'd1, 5'd12, OpCode_OpIMM));
    emit(immOp(12'd13, 5'd2, 3'd5, 5'd13, OpCode_OpIMM));
    emit(immOp({7'h20, 5'd13}, 5'd2, 3'd5, 5'd14, OpCode_OpIMM));
    emit(immOp({7'h20, 5'd31}, 5'd2, 3'd5, 5'd15, OpCode_OpIMM));
    emit(upperImm(20'($random(seed)), 5'd16, OpCode_LUI));
    emit(upperImm(20'h12345, 5'd17, OpCode_AUIPC));
    emit(upperImm(20'h0, 5'd18, OpCode_AUIPC));
    emit(ECALL_WORD);
    progLen[1] = allWords.size() - progStart[1];

    progStart[2] = allWords.size();
    testName[2]  = "back-to-back dependencies";
    setConst(5'd1, $random(seed));
    setConst(5'd2, $random(seed));
    emit(regOp(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
    emit(regOp(7'h20, 5'd1, 5'd3, 3'd0, 5'd4));      // rs1 at distance one
    emit(regOp(7'h00, 5'd3, 5'd4, 3'd4, 5'd5));      // rs2 at distance two
    emit(regOp(7'h00, 5'd5, 5'd5, 3'd7, 5'd6));
    emit(immOp(12'd1, 5'd6, 3'd0, 5'd7, OpCode_OpIMM));
    emit(regOp(7'h00, 5'd7, 5'd6, 3'd6, 5'd8));
    emit(regOp(7'h00, 5'd7, 5'd8, 3'd1, 5'd9));
    emit(regOp(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
    emit(regOp(7'h00, 5'd0, 5'd0, 3'd0, 5'd10));     // x0 must not be forwarded
    emit(regOp(7'h00, 5'd9, 5'd0, 3'd0, 5'd11));
    emit(ECALL_WORD);
    progLen[2] = allWords.size() - progStart[2];

    progStart[3] = allWords.size();
    testName[3]  = "control flow";
    setConst(5'd1, 32'hffff_fffd);
    setConst(5'd2, 32'd5);
    for (int c = 0; c < 6; c++) begin
        for (int p = 0; p < 3; p++) begin
            emit(branchTo(brF3[c], brA[p], brB[p], 13'd12));
            emit(immOp(12'd1, 5'd10, 3'd0, 5'd10, OpCode_OpIMM));
            emit(immOp(12'd1, 5'd10, 3'd0, 5'd10, OpCode_OpIMM));
        end
    end
    emit(jumpTo(5'd5, 21'd12));
    emit(immOp(12'd1, 5'd11, 3'd0, 5'd11, OpCode_OpIMM));
    emit(immOp(12'd1, 5'd11, 3'd0, 5'd11, OpCode_OpIMM));
    emit(upperImm(20'h0, 5'd6, OpCode_AUIPC));
    emit(immOp(12'd16, 5'd6, 3'd0, 5'd7, OpCode_JALR));
    emit(immOp(12'd1, 5'd11, 3'd0, 5'd11, OpCode_OpIMM));
    emit(immOp(12'd1, 5'd11, 3'd0, 5'd11, OpCode_OpIMM));
    emit(upperImm(20'h0, 5'd6, OpCode_AUIPC));
    emit(immOp(12'd13, 5'd6, 3'd0, 5'd8, OpCode_JALR)); // Odd target, bit 0 dropped
    emit(immOp(12'd1, 5'd11, 3'd0, 5'd11, OpCode_OpIMM));
    emit(regOp(7'h00, 5'd7, 5'd5, 3'd0, 5'd12));
    emit(regOp(7'h00, 5'd8, 5'd12, 3'd0, 5'd13));
    emit(ECALL_WORD);
    progLen[3] = allWords.size() - progStart[3];

    progStart[4] = allWords.size();
    testName[4]  = "halt and reset";
    setConst(5'd1, $random(seed));
    emit(immOp(12'd1, 5'd1, 3'd0, 5'd2, OpCode_OpIMM));
    emit(EBREAK_WORD);
    emit(immOp(12'd1, 5'd2, 3'd0, 5'd3, OpCode_OpIMM)); // Never retires
    emit(immOp(12'd1, 5'd3, 3'd0, 5'd4, OpCode_OpIMM));
    progLen[4] = allWords.size() - progStart[4];
endfunction

`endif

// File: tests/CoreTb.sv
`timescale 1ns/10ps

module CoreTb
    import Types::*;
();

    localparam int              MEM_WORDS  = 256;
    localparam int              NUM_TESTS  = 5;
    localparam logic [XLEN-1:0] RESET_ADDR = '0;

    logic                  clock;
    logic                  rstN;
    logic [INST_WIDTH-1:0] instData;
    logic [XLEN-1:0]       instAddr;
    logic                  retireValid;
    logic [XLEN-1:0]       retirePc;
    logic [4:0]            retireRd;
    logic [XLEN-1:0]       retireData;
    logic                  halted;

    logic [31:0]     progMem [MEM_WORDS];
    logic [31:0]     allWords [$];          // All programs back to back
    int              progStart [NUM_TESTS];
    int              progLen [NUM_TESTS];
    string           testName [NUM_TESTS];
    logic [XLEN-1:0] expPc [$];             // Expected retire records
    logic [4:0]      expRd [$];
    logic [XLEN-1:0] expData [$];

    int              seed = 32'hef07;
    int              modelCount;
    int              retiredCount;
    int              testErrors;
    int              passCount;
    int              failCount;
    int              cycles;
    int              cycleLimit;
    int              sinceRelease;
    int              haltedCycles;
    logic            checking;
    logic            testDone;
    logic [XLEN-1:0] addrPrev;
    logic [XLEN-1:0] addrMid;
    logic [XLEN-1:0] addrOld;               // Fetch address three samples back

    `include "IsaModel.svh"

    Core #(
        .REG_WIDTH  (5),
        .RESET_ADDR (RESET_ADDR))
    dut_i (
        .i_clock       (clock),
        .i_rstN        (rstN),
        .i_instData    (instData),
        .o_instAddr    (instAddr),
        .o_retireValid (retireValid),
        .o_retirePc    (retirePc),
        .o_retireRd    (retireRd),
        .o_retireData  (retireData),
        .o_halted      (halted));

    assign instData = progMem[instAddr[9:2]];   // Same-cycle instruction memory

    initial clock = 1'b0;
    always #10 clock = ~clock;

    task automatic flagMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        testErrors++;
    endtask

    task automatic noteProblem(input string what);
        $display("Error at %0t: %s", $time, what);
        testErrors++;
    endtask

    // ADDI x0, x0, index as filler so stray fetches are harmless
    task automatic placeProgram(input int t);
        for (int i = 0; i < MEM_WORDS; i++)
            progMem[i] = immOp(12'(i), 5'd0, 3'd0, 5'd0, OpCode_OpIMM);
        for (int i = 0; i < progLen[t]; i++)
            progMem[i] = allWords[progStart[t] + i];
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles, the core never finished a program", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // Retire checker sampling on the falling edge
    always @(negedge clock) begin
        if (checking) begin
            if (sinceRelease == 0) begin
                assert (instAddr == RESET_ADDR)
                    else flagMismatch("o_instAddr", RESET_ADDR, instAddr);
            end
            if (sinceRelease < 3) begin
                assert (!retireValid)
                    else noteProblem("o_retireValid rose before any instruction reached execute");
            end
            if (retireValid) begin
                retiredCount++;
                assert (expPc.size() > 0)
                    else noteProblem("an instruction retired after the halting instruction");
                if (expPc.size() > 0) begin
                    assert (retirePc == expPc[0])
                        else flagMismatch("o_retirePc", expPc[0], retirePc);
                    assert (retirePc == addrOld)          // Fetched three samples earlier
                        else flagMismatch("o_retirePc vs o_instAddr", addrOld, retirePc);
                    assert (retireRd == expRd[0])
                        else flagMismatch("o_retireRd", 32'(expRd[0]), 32'(retireRd));
                    assert (retireData == expData[0])
                        else flagMismatch("o_retireData", expData[0], retireData);
                    void'(expPc.pop_front());
                    void'(expRd.pop_front());
                    void'(expData.pop_front());
                end
            end
            assert (halted == (expPc.size() == 0))
                else flagMismatch("o_halted", 32'(expPc.size() == 0), 32'(halted));
            if (halted)
                haltedCycles++;
            if (haltedCycles == 4)
                testDone = 1'b1;                          // Quiet window after halt
            addrOld  = addrMid;
            addrMid  = addrPrev;
            addrPrev = instAddr;
            sinceRelease++;
        end
    end

    initial begin
        rstN      = 1'b0;
        checking  = 1'b0;
        testDone  = 1'b0;
        passCount = 0;
        failCount = 0;
        buildPrograms();
        placeProgram(0);
        cycleLimit = allWords.size() * 4 + 100;
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clock);
            rstN <= 1'b0;
            @(negedge clock);
            retiredCount = 0;
            testErrors   = 0;
            sinceRelease = 0;
            haltedCycles = 0;
            testDone     = 1'b0;
            addrPrev     = '0;
            addrMid      = '0;
            addrOld      = '0;
            placeProgram(t);
            runModel();
            repeat (3) @(posedge clock);
            rstN     <= 1'b1;
            checking <= 1'b1;
            while (!testDone)
                @(posedge clock);
            checking <= 1'b0;
            assert (retiredCount == modelCount)
                else flagMismatch("retire count", modelCount, retiredCount);
            if (testErrors == 0)
                passCount++;
            else
                failCount++;
            $display("Test %0d %s: %s, %0d retires, %0d errors", t + 1, testName[t],
                     (testErrors == 0) ? "ok" : "wrong", retiredCount, testErrors);
        end
        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: verilog/Core.sv
`timescale 1ns/10ps

module Core
    import Types::*;
#(
    parameter REG_WIDTH = 5,
    parameter logic [XLEN-1:0] RESET_ADDR = '0)
 (
    input  logic                  i_clock,
    input  logic                  i_rstN,
    input  logic [INST_WIDTH-1:0] i_instData,
    output logic [XLEN-1:0]       o_instAddr,
    output logic                  o_retireValid,
    output logic [XLEN-1:0]       o_retirePc,
    output logic [REG_WIDTH-1:0]  o_retireRd,
    output logic [XLEN-1:0]       o_retireData,
    output logic                  o_halted);

    logic                  fdValid;
    logic [INST_WIDTH-1:0] fdInst;
    logic [XLEN-1:0]       fdPc;
    logic                  redirect;
    logic [XLEN-1:0]       target;
    logic                  halted;
    logic                  wbValid;
    logic [XLEN-1:0]       wbPc;
    logic [REG_WIDTH-1:0]  wbRd;
    logic [XLEN-1:0]       wbData;

    DecodedInst #(.REG_WIDTH(REG_WIDTH)) deBus ();

    FetchStage #(
        .RESET_ADDR (RESET_ADDR))
    fetch_i (
        .i_clock    (i_clock),
        .i_rstN     (i_rstN),
        .i_redirect (redirect),
        .i_target   (target),
        .i_halted   (halted),
        .i_instData (i_instData),
        .o_instAddr (o_instAddr),
        .o_fdValid  (fdValid),
        .o_fdInst   (fdInst),
        .o_fdPc     (fdPc));

    DecodeStage #(
        .REG_WIDTH (REG_WIDTH))
    decode_i (
        .i_clock   (i_clock),
        .i_rstN    (i_rstN),
        .i_fdValid (fdValid),
        .i_fdInst  (fdInst),
        .i_fdPc    (fdPc),
        .i_flush   (redirect),
        .i_halted  (halted),
        .i_wbValid (wbValid),
        .i_wbRd    (wbRd),
        .i_wbData  (wbData),
        .o_de      (deBus.producer));

    ExecuteStage #(
        .REG_WIDTH (REG_WIDTH))
    execute_i (
        .i_de       (deBus.consumer),
        .i_clock    (i_clock),
        .i_rstN     (i_rstN),
        .o_redirect (redirect),
        .o_target   (target),
        .o_halted   (halted),
        .o_wbValid  (wbValid),
        .o_wbPc     (wbPc),
        .o_wbRd     (wbRd),
        .o_wbData   (wbData));

    // Retire port is the execute output register
    assign o_retireValid = wbValid;
    assign o_retirePc    = wbPc;
    assign o_retireRd    = wbRd;
    assign o_retireData  = wbData;
    assign o_halted      = halted;

endmodule

// File: verilog/DecodeStage.sv
`timescale 1ns/10ps

module DecodeStage
    import Types::*;
#(
    parameter REG_WIDTH = 5)
 (
    input  logic                  i_clock,
    input  logic                  i_rstN,
    input  logic                  i_fdValid,
    input  logic [INST_WIDTH-1:0] i_fdInst,
    input  logic [XLEN-1:0]       i_fdPc,
    input  logic                  i_flush,     // Redirect from execute
    input  logic                  i_halted,
    input  logic                  i_wbValid,   // Retire register, drives the write port
    input  logic [REG_WIDTH-1:0]  i_wbRd,
    input  logic [XLEN-1:0]       i_wbData,
    DecodedInst.producer          o_de);

    OpCode                op;
    AluOp                 aluOp;
    logic [REG_WIDTH-1:0] rs1;
    logic [REG_WIDTH-1:0] rs2;
    logic [REG_WIDTH-1:0] rd;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      rs1Val;
    logic [XLEN-1:0]      rs2Val;
    logic                 isAlu;
    logic                 isEcall;
    logic                 isEbreak;
    logic                 writesRd;
    logic [2:0]           funct3;
    logic                 altFn;       // funct7[5], selects SUB and SRA

    Decoder_RV32I #(
        .REG_WIDTH (REG_WIDTH))
    decoder_i (
        .i_Inst     (i_fdInst),
        .o_OP       (op),
        .o_RS1      (rs1),
        .o_RS2      (rs2),
        .o_RD       (rd),
        .o_IMM      (imm),
        .o_IsLoad   (),            // Loads retire as no-ops
        .o_IsALU    (isAlu),
        .o_IsECALL  (isEcall),
        .o_IsEBREAK (isEbreak));

    RegisterFile #(
        .REG_WIDTH (REG_WIDTH))
    regFile_i (
        .i_clock   (i_clock),
        .i_rstN    (i_rstN),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .i_wrValid (i_wbValid),
        .i_wrRd    (i_wbRd),
        .i_wrData  (i_wbData),
        .o_rs1Val  (rs1Val),
        .o_rs2Val  (rs2Val));

    assign funct3 = i_fdInst[14:12];
    assign altFn  = i_fdInst[30];

    always_comb begin
        unique case (funct3)
            3'b000:  aluOp = (op == OpCode_Op && altFn) ? AluSub : AluAdd; // No SUBI
            3'b001:  aluOp = AluSll;
            3'b010:  aluOp = AluSlt;
            3'b011:  aluOp = AluSltu;
            3'b100:  aluOp = AluXor;
            3'b101:  aluOp = altFn ? AluSra : AluSrl;
            3'b110:  aluOp = AluOr;
            default: aluOp = AluAnd;
        endcase
        if (!isAlu)
            aluOp = AluAdd;
    end

    // Branches, loads, stores and system write nothing
    always_comb begin
        case (op)
            OpCode_LUI, OpCode_AUIPC, OpCode_JAL, OpCode_JALR: writesRd = 1'b1;
            default:                                           writesRd = isAlu;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_rstN)
            o_de.valid <= 1'b0;
        else
            o_de.valid <= i_fdValid & ~i_flush & ~i_halted;
    end

    always_ff @(posedge i_clock) begin
        o_de.op       <= op;
        o_de.aluOp    <= aluOp;
        o_de.useImm   <= op == OpCode_OpIMM;
        o_de.branchFn <= BranchFn'(funct3);
        o_de.rd       <= rd;
        o_de.rs1      <= rs1;
        o_de.rs2      <= rs2;
        o_de.rs1Val   <= rs1Val;
        o_de.rs2Val   <= rs2Val;
        o_de.imm      <= imm;
        o_de.pc       <= i_fdPc;
        o_de.isHalt   <= isEcall | isEbreak;
        o_de.writesRd <= writesRd;
    end

endmodule

// File: verilog/Decoder_RV32I.sv
`timescale 1ns/10ps

module Decoder_RV32I
    import Types::*;
#(
    parameter REG_WIDTH = 5)
 (
    input  logic [INST_WIDTH-1:0] i_Inst,      // Instruction word
    output OpCode                 o_OP,        // Major opcode
    output logic [REG_WIDTH-1:0]  o_RS1,       // Source register 1
    output logic [REG_WIDTH-1:0]  o_RS2,       // Source register 2
    output logic [REG_WIDTH-1:0]  o_RD,        // Destination register
    output logic [XLEN-1:0]       o_IMM,       // Extended immediate
    output logic                  o_IsLoad,    // LOAD class
    output logic                  o_IsALU,     // OP or OP-IMM class
    output logic                  o_IsECALL,
    output logic                  o_IsEBREAK);

    // Immediate by format, keyed on funct3 and opcode
    always_comb begin
        unique casez ({i_Inst[14:12], i_Inst[6:0]})
            {3'b???, OpCode_LUI  },
            {3'b???, OpCode_AUIPC}:                               // U type
                o_IMM = {i_Inst[31:12], 12'b0};

            {3'b???, OpCode_JAL}:                                 // J type
                o_IMM = {{(XLEN-20){i_Inst[31]}}, i_Inst[19:12], i_Inst[20],
                         i_Inst[30:21], 1'b0};

            {3'b???, OpCode_Branch}:                              // B type
                o_IMM = {{(XLEN-12){i_Inst[31]}}, i_Inst[7], i_Inst[30:25],
                         i_Inst[11:8], 1'b0};

            {3'b001, OpCode_OpIMM},
            {3'b101, OpCode_OpIMM}:                               // Shift amount
                o_IMM = {{(XLEN-SHAMT_WIDTH){1'b0}}, i_Inst[24:20]};

            {3'b???, OpCode_Load},
            {3'b000, OpCode_OpIMM},
            {3'b010, OpCode_OpIMM},
            {3'b011, OpCode_OpIMM},
            {3'b100, OpCode_OpIMM},
            {3'b110, OpCode_OpIMM},
            {3'b111, OpCode_OpIMM},
            {3'b000, OpCode_JALR}:                                // I type
                o_IMM = {{(XLEN-12){i_Inst[31]}}, i_Inst[31:20]};

            {3'b???, OpCode_Store}:                               // S type
                o_IMM = {{(XLEN-12){i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};

            default:
                o_IMM = '0;
        endcase
    end

    assign o_OP = OpCode'(i_Inst[6:0]);

    // Low bits of each field, narrower on the 16-register variant
    assign o_RS1 = i_Inst[REG_WIDTH+14:15];
    assign o_RS2 = i_Inst[REG_WIDTH+19:20];
    assign o_RD  = i_Inst[REG_WIDTH+6:7];

    assign o_IsLoad   = i_Inst[6:0] == OpCode_Load;
    assign o_IsALU    = (i_Inst[6:0] == OpCode_Op) | (i_Inst[6:0] == OpCode_OpIMM);

    // ECALL and EBREAK differ only in imm[0]
    assign o_IsECALL  = (i_Inst[6:0] == OpCode_System) & (i_Inst[14:12] == 3'b000) &
                        (i_Inst[31:20] == 12'h000);
    assign o_IsEBREAK = (i_Inst[6:0] == OpCode_System) & (i_Inst[14:12] == 3'b000) &
                        (i_Inst[31:20] == 12'h001);

endmodule

// File: verilog/ExecuteStage.sv
`timescale 1ns/10ps

module ExecuteStage
    import Types::*;
#(
    parameter REG_WIDTH = 5)
 (
    DecodedInst.consumer         i_de,
    input  logic                 i_clock,
    input  logic                 i_rstN,
    output logic                 o_redirect,   // One-cycle flush pulse
    output logic [XLEN-1:0]      o_target,
    output logic                 o_halted,
    output logic                 o_wbValid,    // Retire register
    output logic [XLEN-1:0]      o_wbPc,
    output logic [REG_WIDTH-1:0] o_wbRd,       // Zero when nothing is written
    output logic [XLEN-1:0]      o_wbData);

    logic            exValid;
    logic            fwdA;
    logic            fwdB;
    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluRes;
    logic [XLEN-1:0] result;
    logic            taken;
    logic            writes;

    assign exValid = i_de.valid & ~o_halted;   // Nothing retires after a halt

    // Bypass from the instruction that retired last cycle
    assign fwdA = o_wbValid && o_wbRd != '0 && o_wbRd == i_de.rs1;
    assign fwdB = o_wbValid && o_wbRd != '0 && o_wbRd == i_de.rs2;
    assign opA  = fwdA ? o_wbData : i_de.rs1Val;
    assign opB  = fwdB ? o_wbData : i_de.rs2Val;
    assign aluB = i_de.useImm ? i_de.imm : opB;

    always_comb begin
        case (i_de.aluOp)
            AluSub:  aluRes = opA - aluB;
            AluSll:  aluRes = opA << aluB[SHAMT_WIDTH-1:0];
            AluSlt:  aluRes = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
            AluSltu: aluRes = {{(XLEN-1){1'b0}}, opA < aluB};
            AluXor:  aluRes = opA ^ aluB;
            AluSrl:  aluRes = opA >> aluB[SHAMT_WIDTH-1:0];
            AluSra:  aluRes = $signed(opA) >>> aluB[SHAMT_WIDTH-1:0];
            AluOr:   aluRes = opA | aluB;
            AluAnd:  aluRes = opA & aluB;
            default: aluRes = opA + aluB;
        endcase
    end

    always_comb begin
        case (i_de.op)
            OpCode_LUI:              result = i_de.imm;
            OpCode_AUIPC:            result = i_de.pc + i_de.imm;
            OpCode_JAL, OpCode_JALR: result = i_de.pc + XLEN'(4);   // Link value
            default:                 result = aluRes;
        endcase
    end

    always_comb begin
        case (i_de.branchFn)
            Beq:     taken = opA == opB;
            Bne:     taken = opA != opB;
            Blt:     taken = $signed(opA) < $signed(opB);
            Bge:     taken = $signed(opA) >= $signed(opB);
            Bltu:    taken = opA < opB;
            Bgeu:    taken = opA >= opB;
            default: taken = 1'b0;
        endcase
    end

    assign o_redirect = exValid & ((i_de.op == OpCode_Branch && taken) ||
                                   i_de.op == OpCode_JAL || i_de.op == OpCode_JALR);

    // JALR target is rs1 based with bit 0 cleared
    assign o_target = (i_de.op == OpCode_JALR) ? ((opA + i_de.imm) & ~XLEN'(1)) :
                                                 i_de.pc + i_de.imm;

    assign writes = i_de.writesRd & (i_de.rd != '0);

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            o_wbValid <= 1'b0;
            o_halted  <= 1'b0;
        end
        else begin
            o_wbValid <= exValid;
            if (exValid && i_de.isHalt)
                o_halted <= 1'b1;            // Held until reset
        end
    end

    always_ff @(posedge i_clock) begin
        o_wbPc   <= i_de.pc;
        o_wbRd   <= writes ? i_de.rd : '0;
        o_wbData <= writes ? result : '0;
    end

endmodule

// File: verilog/FetchStage.sv
`timescale 1ns/10ps

module FetchStage
    import Types::*;
#(
    parameter logic [XLEN-1:0] RESET_ADDR = '0)
 (
    input  logic                  i_clock,
    input  logic                  i_rstN,
    input  logic                  i_redirect,    // Taken branch or jump
    input  logic [XLEN-1:0]       i_target,
    input  logic                  i_halted,
    input  logic [INST_WIDTH-1:0] i_instData,    // Same-cycle memory answer
    output logic [XLEN-1:0]       o_instAddr,
    output logic                  o_fdValid,
    output logic [INST_WIDTH-1:0] o_fdInst,
    output logic [XLEN-1:0]       o_fdPc);

    logic [XLEN-1:0] pc;

    assign o_instAddr = pc;

    always_ff @(posedge i_clock) begin
        if (!i_rstN) begin
            pc        <= RESET_ADDR;
            o_fdValid <= 1'b0;
        end
        else begin
            if (i_redirect)
                pc <= i_target;
            else if (!i_halted)
                pc <= pc + XLEN'(4);
            // Word on the bus during a redirect is the wrong path
            o_fdValid <= ~i_redirect & ~i_halted;
        end
    end

    always_ff @(posedge i_clock) begin
        o_fdInst <= i_instData;
        o_fdPc   <= pc;
    end

endmodule

// File: verilog/RegisterFile.sv
`timescale 1ns/10ps

module RegisterFile
    import Types::*;
#(
    parameter REG_WIDTH = 5)
 (
    input  logic                 i_clock,
    input  logic                 i_rstN,
    input  logic [REG_WIDTH-1:0] i_rs1,
    input  logic [REG_WIDTH-1:0] i_rs2,
    input  logic                 i_wrValid,
    input  logic [REG_WIDTH-1:0] i_wrRd,
    input  logic [XLEN-1:0]      i_wrData,
    output logic [XLEN-1:0]      o_rs1Val,
    output logic [XLEN-1:0]      o_rs2Val);

    logic [XLEN-1:0] regs [2**REG_WIDTH];
    logic            wrEn;

    assign wrEn = i_wrValid & (i_wrRd != '0);     // x0 never written

    always_ff @(posedge i_clock) begin
        if (!i_rstN)
            regs <= '{default: '0};
        else if (wrEn)
            regs[i_wrRd] <= i_wrData;
    end

    // Write-through so decode sees the value retiring this cycle
    assign o_rs1Val = (wrEn && i_wrRd == i_rs1) ? i_wrData : regs[i_rs1];
    assign o_rs2Val = (wrEn && i_wrRd == i_rs2) ? i_wrData : regs[i_rs2];

endmodule

// File: verilog/StageIf.sv
`timescale 1ns/10ps

interface DecodedInst
    import Types::*;
#(
    parameter REG_WIDTH = 5);

    logic                 valid;       // Slot holds a live instruction
    OpCode                op;
    AluOp                 aluOp;
    logic                 useImm;      // Operand B comes from imm
    BranchFn              branchFn;
    logic [REG_WIDTH-1:0] rd;
    logic [REG_WIDTH-1:0] rs1;
    logic [REG_WIDTH-1:0] rs2;
    logic [XLEN-1:0]      rs1Val;      // Values read in decode
    logic [XLEN-1:0]      rs2Val;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      pc;
    logic                 isHalt;      // ECALL or EBREAK
    logic                 writesRd;

    modport producer (
        output valid, op, aluOp, useImm, branchFn, rd, rs1, rs2,
               rs1Val, rs2Val, imm, pc, isHalt, writesRd);

    modport consumer (
        input  valid, op, aluOp, useImm, branchFn, rd, rs1, rs2,
               rs1Val, rs2Val, imm, pc, isHalt, writesRd);

endinterface

// File: verilog/Types.sv
package Types;

    localparam int XLEN        = 32;   // Data and address width
    localparam int INST_WIDTH  = 32;   // Instruction word width
    localparam int SHAMT_WIDTH = 5;    // Shift amount bits used by the ALU

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OpCode_LUI    = 7'b0110111,
        OpCode_AUIPC  = 7'b0010111,
        OpCode_JAL    = 7'b1101111,
        OpCode_JALR   = 7'b1100111,
        OpCode_Branch = 7'b1100011,
        OpCode_Load   = 7'b0000011,
        OpCode_Store  = 7'b0100011,
        OpCode_OpIMM  = 7'b0010011,
        OpCode_Op     = 7'b0110011,
        OpCode_System = 7'b1110011
    } OpCode;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluSll,
        AluSlt,
        AluSltu,
        AluXor,
        AluSrl,
        AluSra,
        AluOr,
        AluAnd
    } AluOp;

    // Branch conditions, funct3 of the branch format
    typedef enum logic [2:0] {
        Beq  = 3'b000,
        Bne  = 3'b001,
        Blt  = 3'b100,
        Bge  = 3'b101,
        Bltu = 3'b110,
        Bgeu = 3'b111
    } BranchFn;

endpackage

// File: vlog.f
+incdir+tests
verilog/Types.sv
verilog/StageIf.sv
verilog/Decoder_RV32I.sv
verilog/RegisterFile.sv
verilog/FetchStage.sv
verilog/DecodeStage.sv
verilog/ExecuteStage.sv
verilog/Core.sv
tests/CoreTb.sv
